// ==== Bender.yml ====
package:
  name: soc_top

sources:
  - source/soc_pkg.sv
  - source/soc_boot_ctrl.sv
  - source/soc_bus_split.sv
  - source/soc_int_mem.sv
  - source/soc_timer.sv
  - source/soc_top.sv
  - target: test
    files:
      - tests/tb_soc_top.sv

// ==== list.f ====
source/soc_pkg.sv
source/soc_boot_ctrl.sv
source/soc_bus_split.sv
source/soc_int_mem.sv
source/soc_timer.sv
source/soc_top.sv
tests/tb_soc_top.sv

// ==== source/soc_boot_ctrl.sv ====
`timescale 1ns/1ps

module soc_boot_ctrl #(
   parameter int RST_CYCLES = 4
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  soc_pkg::iob_req_t  req_i,
   output soc_pkg::iob_resp_t resp_o,
   output logic              boot_o,
   output logic              cpu_reset_o
);

   import soc_pkg::*;

   localparam int CNT_W = (RST_CYCLES > 1) ? $clog2(RST_CYCLES) : 1;

   typedef logic [CNT_W-1:0] rst_cnt_t;

   // counter runs down to zero, so load one less than the length
   localparam rst_cnt_t RST_LOAD = rst_cnt_t'(RST_CYCLES - 1);

   boot_state_t state_q;
   boot_state_t state_d;
   rst_cnt_t    cnt_q;
   rst_cnt_t    cnt_d;
   logic        rd_req;
   logic        clear_req;
   logic        rvalid_q;
   data_t       rdata_q;

   // boot flag lives in the state, the register reads it back in bit 0
   assign boot_o      = (state_q == ST_HOLD) || (state_q == ST_BOOT);
   assign cpu_reset_o = (state_q == ST_HOLD) || (state_q == ST_SWITCH);

   assign rd_req = req_i.valid && (req_i.wstrb == '0);

   // only byte 0 matters, and only a zero in bit 0 clears boot
   assign clear_req = req_i.valid && req_i.wstrb[0] && !req_i.wdata[0];

   always_comb begin
      state_d = state_q;
      cnt_d   = cnt_q;
      case (state_q)
         ST_HOLD: begin
            if (cnt_q == '0) begin
               state_d = ST_BOOT;
            end else begin
               cnt_d = cnt_q - 1'b1;
            end
         end
         ST_BOOT: begin
            // leave boot mode and hold the cpu again
            if (clear_req) begin
               state_d = ST_SWITCH;
               cnt_d   = RST_LOAD;
            end
         end
         ST_SWITCH: begin
            if (cnt_q == '0) begin
               state_d = ST_RUN;
            end else begin
               cnt_d = cnt_q - 1'b1;
            end
         end
         ST_RUN: begin
            // stays here until rst_i
            state_d = ST_RUN;
         end
         default: begin
            state_d = ST_HOLD;
            cnt_d   = RST_LOAD;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q  <= ST_HOLD;
         cnt_q    <= RST_LOAD;
         rvalid_q <= 1'b0;
      end else begin
         state_q  <= state_d;
         cnt_q    <= cnt_d;
         rvalid_q <= rd_req;
      end
   end

   // read value is the flag as seen at the request edge
   always_ff @(posedge clk_i) begin
      rdata_q <= {{(DATA_W-1){1'b0}}, boot_o};
   end

   assign resp_o.rvalid = rvalid_q;
   assign resp_o.rdata  = rdata_q;

endmodule

// ==== source/soc_bus_split.sv ====
`timescale 1ns/1ps

module soc_bus_split (
   input  logic              clk_i,
   input  logic              rst_i,
   input  soc_pkg::iob_req_t  m_req_i,
   output soc_pkg::iob_resp_t m_resp_o,
   output soc_pkg::iob_req_t  mem_req_o,
   output soc_pkg::iob_req_t  boot_req_o,
   output soc_pkg::iob_req_t  timer_req_o,
   input  soc_pkg::iob_resp_t mem_resp_i,
   input  soc_pkg::iob_resp_t boot_resp_i,
   input  soc_pkg::iob_resp_t timer_resp_i
);

   import soc_pkg::*;

   // what was asked for on the previous cycle
   typedef struct packed {
      logic       rd;
      slave_sel_t sel;
   } rsp_rec_t;

   slave_sel_t sel;
   rsp_rec_t   rec_d;
   rsp_rec_t   rec_q;

   assign sel = m_req_i.addr[SEL_MSB:SEL_LSB];

   // fields go to every slave, valid only to the addressed one
   always_comb begin
      mem_req_o   = m_req_i;
      boot_req_o  = m_req_i;
      timer_req_o = m_req_i;

      mem_req_o.valid   = m_req_i.valid && (sel == SEL_MEM);
      boot_req_o.valid  = m_req_i.valid && (sel == SEL_BOOT);
      timer_req_o.valid = m_req_i.valid && (sel == SEL_TIMER);
   end

   assign rec_d.rd  = m_req_i.valid && (m_req_i.wstrb == '0);
   assign rec_d.sel = sel;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rec_q <= '0;
      end else begin
         rec_q <= rec_d;
      end
   end

   // response picked by last cycle's selection
   always_comb begin
      m_resp_o = '0;
      case (rec_q.sel)
         SEL_MEM: begin
            m_resp_o = mem_resp_i;
         end
         SEL_BOOT: begin
            m_resp_o = boot_resp_i;
         end
         SEL_TIMER: begin
            m_resp_o = timer_resp_i;
         end
         default: begin
            // unmapped, answer reads with zero
            m_resp_o.rvalid = rec_q.rd;
            m_resp_o.rdata  = '0;
         end
      endcase
   end

endmodule

// ==== source/soc_int_mem.sv ====
`timescale 1ns/1ps

module soc_int_mem #(
   parameter int SRAM_ADDR_W    = 12,
   parameter int BOOTROM_ADDR_W = 10
) (
   input  logic                      clk_i,
   input  logic                      rst_i,
   input  logic                      boot_i,

   // instruction side
   input  soc_pkg::iob_req_t          i_req_i,
   output soc_pkg::iob_resp_t         i_resp_o,

   // data side
   input  soc_pkg::iob_req_t          d_req_i,
   output soc_pkg::iob_resp_t         d_resp_o,

   // boot rom
   output logic                      rom_r_valid_o,
   output logic [BOOTROM_ADDR_W-3:0] rom_r_addr_o,
   input  soc_pkg::data_t             rom_r_rdata_i,

   // sram fetch port
   output logic                      i_valid_o,
   output logic [SRAM_ADDR_W-3:0]    i_addr_o,
   input  soc_pkg::data_t             i_rdata_i,

   // sram data port
   output logic                      d_valid_o,
   output logic [SRAM_ADDR_W-3:0]    d_addr_o,
   output soc_pkg::data_t             d_wdata_o,
   output soc_pkg::strb_t             d_wstrb_o,
   input  soc_pkg::data_t             d_rdata_i
);

   logic i_rd_q;
   logic i_rom_q;
   logic d_rd_q;

   // fetches go to rom while booting and to sram after
   // no memory strobes while rst_i is high
   assign rom_r_valid_o = i_req_i.valid && boot_i && !rst_i;
   assign rom_r_addr_o  = i_req_i.addr[BOOTROM_ADDR_W-1:2];
   assign i_valid_o     = i_req_i.valid && !boot_i && !rst_i;
   assign i_addr_o      = i_req_i.addr[SRAM_ADDR_W-1:2];

   // data side always targets sram by word address
   assign d_valid_o = d_req_i.valid && !rst_i;
   assign d_addr_o  = d_req_i.addr[SRAM_ADDR_W-1:2];
   assign d_wdata_o = d_req_i.wdata;
   assign d_wstrb_o = d_req_i.wstrb;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         i_rd_q <= 1'b0;
         d_rd_q <= 1'b0;
      end else begin
         i_rd_q <= i_req_i.valid;
         d_rd_q <= d_req_i.valid && (d_req_i.wstrb == '0);
      end
   end

   // source of the fetch in flight keeps rom data for a fetch
   // issued right before the switch
   always_ff @(posedge clk_i) begin
      i_rom_q <= boot_i;
   end

   assign i_resp_o.rvalid = i_rd_q;
   assign i_resp_o.rdata  = i_rom_q ? rom_r_rdata_i : i_rdata_i;

   assign d_resp_o.rvalid = d_rd_q;
   assign d_resp_o.rdata  = d_rdata_i;

endmodule

// ==== source/soc_pkg.sv ====
package soc_pkg;

   // fixed bus widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 32;
   localparam int STRB_W = DATA_W / 8;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [STRB_W-1:0] strb_t;

   // request from a master, all strobes zero means read
   typedef struct packed {
      logic  valid;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } iob_req_t;

   // response, rvalid pulses one cycle after a read
   typedef struct packed {
      logic  rvalid;
      data_t rdata;
   } iob_resp_t;

   // slave index taken from the top two address bits
   localparam int SEL_MSB = ADDR_W - 1;
   localparam int SEL_LSB = ADDR_W - 2;

   typedef logic [SEL_MSB-SEL_LSB:0] slave_sel_t;

   localparam slave_sel_t SEL_MEM   = 2'd0;
   localparam slave_sel_t SEL_BOOT  = 2'd1;
   localparam slave_sel_t SEL_TIMER = 2'd2;

   // boot sequencing
   typedef enum logic [1:0] {
      ST_HOLD,
      ST_BOOT,
      ST_SWITCH,
      ST_RUN
   } boot_state_t;

endpackage

// ==== source/soc_timer.sv ====
`timescale 1ns/1ps

module soc_timer (
   input  logic              clk_i,
   input  logic              rst_i,
   input  soc_pkg::iob_req_t  req_i,
   output soc_pkg::iob_resp_t resp_o
);

   import soc_pkg::*;

   data_t count_q;
   logic  en_q;
   logic  wr_req;
   logic  rd_req;
   logic  ctrl_wr;
   logic  rvalid_q;
   data_t rdata_q;

   assign wr_req = req_i.valid && (req_i.wstrb != '0);
   assign rd_req = req_i.valid && (req_i.wstrb == '0);

   // word 0 is control, enable in bit 0 and clear in bit 1
   assign ctrl_wr = wr_req && !req_i.addr[2] && req_i.wstrb[0];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         count_q  <= '0;
         en_q     <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_req;
         if (ctrl_wr) begin
            en_q <= req_i.wdata[0];
         end
         // clear wins over the increment on the same edge
         if (ctrl_wr && req_i.wdata[1]) begin
            count_q <= '0;
         end else if (en_q) begin
            count_q <= count_q + 1'b1;
         end
      end
   end

   // value before this edge's increment
   always_ff @(posedge clk_i) begin
      rdata_q <= req_i.addr[2] ? count_q : {{(DATA_W-1){1'b0}}, en_q};
   end

   assign resp_o.rvalid = rvalid_q;
   assign resp_o.rdata  = rdata_q;

endmodule

// ==== source/soc_top.sv ====
`timescale 1ns/1ps

module soc_top #(
   parameter int SRAM_ADDR_W    = 12,
   parameter int BOOTROM_ADDR_W = 10,
   parameter int RST_CYCLES     = 4
) (
   input  logic                      clk_i,
   input  logic                      rst_i,

   // cpu buses, driven from outside
   input  soc_pkg::iob_req_t          cpu_i_req_i,
   output soc_pkg::iob_resp_t         cpu_i_resp_o,
   input  soc_pkg::iob_req_t          cpu_d_req_i,
   output soc_pkg::iob_resp_t         cpu_d_resp_o,

   // boot rom
   output logic                      rom_r_valid_o,
   output logic [BOOTROM_ADDR_W-3:0] rom_r_addr_o,
   input  soc_pkg::data_t             rom_r_rdata_i,

   // sram
   output logic                      i_valid_o,
   output logic [SRAM_ADDR_W-3:0]    i_addr_o,
   input  soc_pkg::data_t             i_rdata_i,
   output logic                      d_valid_o,
   output logic [SRAM_ADDR_W-3:0]    d_addr_o,
   output soc_pkg::data_t             d_wdata_o,
   output soc_pkg::strb_t             d_wstrb_o,
   input  soc_pkg::data_t             d_rdata_i,

   // system control
   output logic                      boot_o,
   output logic                      cpu_reset_o
);

   import soc_pkg::*;

   // data bus slaves
   iob_req_t  mem_req;
   iob_resp_t mem_resp;
   iob_req_t  boot_req;
   iob_resp_t boot_resp;
   iob_req_t  timer_req;
   iob_resp_t timer_resp;

   soc_boot_ctrl #(
      .RST_CYCLES(RST_CYCLES)
   ) boot_ctrl0 (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_i      (boot_req),
      .resp_o     (boot_resp),
      .boot_o     (boot_o),
      .cpu_reset_o(cpu_reset_o)
   );

   soc_bus_split dbus_split0 (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .m_req_i     (cpu_d_req_i),
      .m_resp_o    (cpu_d_resp_o),
      .mem_req_o   (mem_req),
      .boot_req_o  (boot_req),
      .timer_req_o (timer_req),
      .mem_resp_i  (mem_resp),
      .boot_resp_i (boot_resp),
      .timer_resp_i(timer_resp)
   );

   soc_int_mem #(
      .SRAM_ADDR_W   (SRAM_ADDR_W),
      .BOOTROM_ADDR_W(BOOTROM_ADDR_W)
   ) int_mem0 (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .boot_i       (boot_o),
      .i_req_i      (cpu_i_req_i),
      .i_resp_o     (cpu_i_resp_o),
      .d_req_i      (mem_req),
      .d_resp_o     (mem_resp),
      .rom_r_valid_o(rom_r_valid_o),
      .rom_r_addr_o (rom_r_addr_o),
      .rom_r_rdata_i(rom_r_rdata_i),
      .i_valid_o    (i_valid_o),
      .i_addr_o     (i_addr_o),
      .i_rdata_i    (i_rdata_i),
      .d_valid_o    (d_valid_o),
      .d_addr_o     (d_addr_o),
      .d_wdata_o    (d_wdata_o),
      .d_wstrb_o    (d_wstrb_o),
      .d_rdata_i    (d_rdata_i)
   );

   soc_timer timer0 (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .req_i (timer_req),
      .resp_o(timer_resp)
   );

endmodule

// ==== tests/tb_soc_top.sv ====
`timescale 1ns/1ps

module tb_soc_top;

   import soc_pkg::*;

   localparam int SRAM_ADDR_W    = 12;
   localparam int BOOTROM_ADDR_W = 10;
   localparam int RST_CYCLES     = 4;
   localparam int SRAM_WORDS     = 2 ** (SRAM_ADDR_W - 2);
   localparam int ROM_WORDS      = 2 ** (BOOTROM_ADDR_W - 2);
   localparam addr_t BOOT_ADDR   = 32'h4000_0000;
   localparam addr_t TIMER_ADDR  = 32'h8000_0000;
   localparam addr_t UNMAP_ADDR  = 32'hC000_0000;

   logic                      clk;
   logic                      rst;
   iob_req_t                  i_req;
   iob_req_t                  d_req;
   iob_resp_t                 i_resp;
   iob_resp_t                 d_resp;
   logic                      rom_valid;
   logic [BOOTROM_ADDR_W-3:0] rom_addr;
   logic                      i_valid;
   logic [SRAM_ADDR_W-3:0]    i_addr;
   logic                      d_valid;
   logic [SRAM_ADDR_W-3:0]    d_addr;
   data_t                     d_wdata;
   strb_t                     d_wstrb;
   data_t                     rom_rdata;
   data_t                     i_rdata;
   data_t                     d_rdata;
   logic                      boot;
   logic                      cpu_reset;

   // external memory copies and the expected model
   data_t rom_tbl[ROM_WORDS];
   data_t ext_sram[SRAM_WORDS];
   data_t exp_sram[SRAM_WORDS];

   // expected responses with the cycle they are due in
   data_t i_exp_q[$];
   int    i_due_q[$];
   data_t d_exp_q[$];
   int    d_due_q[$];

   logic   boot_m;
   logic   tmr_en;
   data_t  tmr_base;
   int     tmr_edge;
   integer seed;
   int     cyc = 0;
   string  test_name;
   int     val_errs;
   int     proto_errs;
   int     timeouts;
   data_t  rom_next;
   data_t  i_next;
   data_t  d_next;
   data_t  wr_data;
   strb_t  wr_strb;
   logic [SRAM_ADDR_W-3:0] wr_addr;
   data_t  popped_data;
   int     popped_due;

   soc_top #(
      .SRAM_ADDR_W   (SRAM_ADDR_W),
      .BOOTROM_ADDR_W(BOOTROM_ADDR_W),
      .RST_CYCLES    (RST_CYCLES)
   ) dut0 (
      .clk_i        (clk),
      .rst_i        (rst),
      .cpu_i_req_i  (i_req),
      .cpu_i_resp_o (i_resp),
      .cpu_d_req_i  (d_req),
      .cpu_d_resp_o (d_resp),
      .rom_r_valid_o(rom_valid),
      .rom_r_addr_o (rom_addr),
      .rom_r_rdata_i(rom_rdata),
      .i_valid_o    (i_valid),
      .i_addr_o     (i_addr),
      .i_rdata_i    (i_rdata),
      .d_valid_o    (d_valid),
      .d_addr_o     (d_addr),
      .d_wdata_o    (d_wdata),
      .d_wstrb_o    (d_wstrb),
      .d_rdata_i    (d_rdata),
      .boot_o       (boot),
      .cpu_reset_o  (cpu_reset)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   function automatic data_t fill_word(input int idx);
      return {6'h2b, idx[9:0], 6'h15, ~idx[9:0]};
   endfunction

   // timer count right after the given edge
   function automatic data_t timer_after(input int edge_no);
      if (tmr_en) begin
         return tmr_base + data_t'(edge_no - tmr_edge);
      end
      return tmr_base;
   endfunction

   task automatic check_value(input string what, input data_t exp, input data_t act);
      assert (act === exp) else begin
         val_errs++;
         $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   // external memories sample strobes at the negedge and answer after the edge
   always begin
      @(negedge clk);
      rom_next = (rom_valid === 1'b1) ? rom_tbl[rom_addr] : rom_rdata;
      i_next   = (i_valid === 1'b1) ? ext_sram[i_addr] : i_rdata;
      d_next   = (d_valid === 1'b1) ? ext_sram[d_addr] : d_rdata;
      wr_strb  = (d_valid === 1'b1) ? d_wstrb : '0;
      wr_addr  = d_addr;
      wr_data  = d_wdata;
      @(posedge clk);
      #1;
      rom_rdata = rom_next;
      i_rdata   = i_next;
      d_rdata   = d_next;
      for (int b = 0; b < 4; b++) begin
         if (wr_strb[b]) begin
            ext_sram[wr_addr][8*b +: 8] = wr_data[8*b +: 8];
         end
      end
   end

   // response monitor for both buses
   always @(negedge clk) begin
      if (i_due_q.size() > 0 && i_due_q[0] == cyc) begin
         popped_data = i_exp_q.pop_front();
         popped_due  = i_due_q.pop_front();
         assert (i_resp.rvalid === 1'b1) else begin
            proto_errs++;
            $display("%s: fetch response due at cycle %0d missing", test_name, popped_due);
         end
         if (i_resp.rvalid === 1'b1) begin
            check_value("fetch rdata", popped_data, i_resp.rdata);
         end
      end else begin
         assert (i_resp.rvalid === 1'b0) else begin
            proto_errs++;
            $display("%s: unexpected fetch response at cycle %0d", test_name, cyc);
         end
      end
      if (d_due_q.size() > 0 && d_due_q[0] == cyc) begin
         popped_data = d_exp_q.pop_front();
         popped_due  = d_due_q.pop_front();
         assert (d_resp.rvalid === 1'b1) else begin
            proto_errs++;
            $display("%s: data response due at cycle %0d missing", test_name, popped_due);
         end
         if (d_resp.rvalid === 1'b1) begin
            check_value("data rdata", popped_data, d_resp.rdata);
         end
      end else begin
         assert (d_resp.rvalid === 1'b0) else begin
            proto_errs++;
            $display("%s: unexpected data response at cycle %0d", test_name, cyc);
         end
      end
   end

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic i_fetch(input addr_t addr);
      int rom_idx;
      int ram_idx;
      rom_idx = addr[BOOTROM_ADDR_W-1:2];
      ram_idx = addr[SRAM_ADDR_W-1:2];
      i_req.valid = 1'b1;
      i_req.addr  = addr;
      i_req.wdata = '0;
      i_req.wstrb = '0;
      i_exp_q.push_back(boot_m ? rom_tbl[rom_idx] : exp_sram[ram_idx]);
      i_due_q.push_back(cyc + 1);
      #1;
      check_value("rom strobe", data_t'(boot_m), data_t'(rom_valid));
      check_value("sram fetch strobe", data_t'(!boot_m), data_t'(i_valid));
      if (boot_m) begin
         check_value("rom address", data_t'(rom_idx), data_t'(rom_addr));
      end else begin
         check_value("fetch address", data_t'(ram_idx), data_t'(i_addr));
      end
      @(posedge clk);
      #1;
      i_req.valid = 1'b0;
   endtask

   task automatic d_access(input addr_t addr, input data_t wdata, input strb_t strb);
      slave_sel_t sel;
      int         idx;
      int         w;
      data_t      exp;
      sel = addr[31:30];
      idx = addr[SRAM_ADDR_W-1:2];
      w   = cyc + 1;
      d_req.valid = 1'b1;
      d_req.addr  = addr;
      d_req.wdata = wdata;
      d_req.wstrb = strb;
      if (strb == '0) begin
         case (sel)
            SEL_MEM:   exp = exp_sram[idx];
            SEL_BOOT:  exp = data_t'(boot_m);
            SEL_TIMER: exp = addr[2] ? timer_after(w - 1) : data_t'(tmr_en);
            default:   exp = '0;
         endcase
         d_exp_q.push_back(exp);
         d_due_q.push_back(w);
      end else if (sel == SEL_MEM) begin
         for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
               exp_sram[idx][8*b +: 8] = wdata[8*b +: 8];
            end
         end
      end else if (sel == SEL_BOOT && strb[0] && !wdata[0]) begin
         boot_m = 1'b0;
      end else if (sel == SEL_TIMER && !addr[2] && strb[0]) begin
         tmr_base = wdata[1] ? '0 : timer_after(w);
         tmr_edge = w;
         tmr_en   = wdata[0];
      end
      #1;
      check_value("sram data strobe", data_t'(sel == SEL_MEM), data_t'(d_valid));
      if (sel == SEL_MEM) begin
         check_value("data address", data_t'(idx), data_t'(d_addr));
         check_value("write strobes", data_t'(strb), data_t'(d_wstrb));
         if (strb != '0) begin
            check_value("write data", wdata, d_wdata);
         end
      end
      @(posedge clk);
      #1;
      d_req.valid = 1'b0;
   endtask

   task automatic drain();
      int n;
      n = 0;
      while ((i_due_q.size() > 0 || d_due_q.size() > 0) && n < 10) begin
         @(posedge clk);
         #1;
         n++;
      end
      assert (i_due_q.size() == 0 && d_due_q.size() == 0) else begin
         timeouts++;
         $display("%s: responses still pending after %0d cycles", test_name, n);
      end
   endtask

   // counts the negedges with cpu reset high from the next one on
   task automatic measure_reset();
      int high;
      int n;
      high = 0;
      n    = 0;
      @(negedge clk);
      while (cpu_reset === 1'b1 && n < 40) begin
         high++;
         n++;
         @(negedge clk);
      end
      assert (n < 40) else begin
         timeouts++;
         $display("%s: cpu reset never released", test_name);
      end
      check_value("cpu reset length", data_t'(RST_CYCLES), data_t'(high));
      @(posedge clk);
      #1;
   endtask

   initial begin
      addr_t a;
      strb_t s;
      rst       = 1'b1;
      i_req     = '0;
      d_req     = '0;
      rom_rdata = '0;
      i_rdata   = '0;
      d_rdata   = '0;
      seed      = 92481;
      boot_m    = 1'b1;
      tmr_en    = 1'b0;
      tmr_base  = '0;
      tmr_edge  = 0;
      val_errs   = 0;
      proto_errs = 0;
      timeouts   = 0;
      for (int k = 0; k < ROM_WORDS; k++) begin
         rom_tbl[k] = data_t'($random(seed));
      end
      for (int k = 0; k < SRAM_WORDS; k++) begin
         ext_sram[k] = fill_word(k);
         exp_sram[k] = fill_word(k);
      end

      test_name = "reset";
      repeat (7) @(posedge clk);
      #1;
      // requests in reset reach no memory and leave sram unchanged
      i_req.valid = 1'b1;
      i_req.addr  = 32'h0000_0010;
      d_req.valid = 1'b1;
      d_req.addr  = 32'h0000_0004;
      d_req.wdata = 32'hDEAD_BEEF;
      d_req.wstrb = 4'hF;
      #1;
      check_value("strobes in reset", '0, data_t'({rom_valid, i_valid, d_valid}));
      @(posedge clk);
      #1;
      i_req = '0;
      d_req = '0;
      check_value("boot flag in reset", 32'd1, data_t'(boot));
      check_value("cpu reset in reset", 32'd1, data_t'(cpu_reset));
      rst = 1'b0;
      measure_reset();
      check_value("boot flag after reset", 32'd1, data_t'(boot));
      d_access(BOOT_ADDR, '0, '0);
      drain();

      test_name = "rom_fetch";
      for (int k = 0; k < 24; k++) begin
         i_fetch(addr_t'($random(seed)) & ~32'h3);
      end
      drain();

      test_name = "sram_data";
      for (int k = 0; k < 64; k++) begin
         a = addr_t'($random(seed)) & 32'h0000_007C;
         s = strb_t'($random(seed));
         if (k % 3 == 0) begin
            s = '0;
         end
         d_access(a, data_t'($random(seed)), s);
      end
      for (int k = 0; k < 32; k++) begin
         d_access(addr_t'(k * 4), '0, '0);
      end
      drain();

      // low bits alias onto sram words that must stay untouched
      test_name = "unmapped";
      for (int k = 0; k < 8; k++) begin
         a = UNMAP_ADDR | (addr_t'($random(seed)) & 32'h0000_007C);
         d_access(a, data_t'($random(seed)), 4'hF);
         d_access(a, '0, '0);
         d_access(a & 32'h0000_0FFF, '0, '0);
      end
      drain();

      test_name = "boot_switch";
      check_value("boot flag before switch", 32'd1, data_t'(boot));
      check_value("cpu reset before switch", '0, data_t'(cpu_reset));
      d_access(BOOT_ADDR, 32'hFFFF_FFFE, 4'h1);
      check_value("boot flag after clear", '0, data_t'(boot));
      measure_reset();

      test_name = "sram_fetch";
      for (int k = 0; k < 24; k++) begin
         i_fetch(addr_t'($random(seed)) & ~32'h3);
      end
      d_access(BOOT_ADDR, 32'h1, 4'hF);
      d_access(BOOT_ADDR, '0, '0);
      drain();
      check_value("boot flag after write of one", '0, data_t'(boot));

      test_name = "timer";
      d_access(TIMER_ADDR, 32'h3, 4'hF);
      idle(2);
      d_access(TIMER_ADDR | 32'h4, '0, '0);
      idle(7);
      d_access(TIMER_ADDR | 32'h4, '0, '0);
      d_access(TIMER_ADDR, '0, '0);
      d_access(TIMER_ADDR, '0, 4'hF);
      idle(3);
      d_access(TIMER_ADDR | 32'h4, '0, '0);
      idle(5);
      d_access(TIMER_ADDR | 32'h4, '0, '0);
      d_access(TIMER_ADDR, '0, '0);
      drain();

      $display("error counts: value %0d, protocol %0d, timeout %0d",
               val_errs, proto_errs, timeouts);
      if (val_errs + proto_errs + timeouts == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule
